// File: sim.f
hw/corr_pkg.sv
hw/div_req_if.sv
hw/norm_divider.sv
hw/lane_scheduler.sv
hw/corr_collector.sv
hw/corr_normalize_top.sv
test/tb_clock.sv
test/corr_tb.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv test/*.sv)

obj_dir/Vcorr_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module corr_tb -f sim.f

run: obj_dir/Vcorr_tb
	@out=$$(./obj_dir/Vcorr_tb); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: test/corr_tb.sv
`timescale 1ns/1ps

module corr_tb;

    localparam int LANES   = 48;
    localparam int DOT_W   = corr_pkg::DOT_W;
    localparam int NORM_W  = corr_pkg::NORM_W;
    localparam int CORR_W  = corr_pkg::CORR_W;
    localparam int LATENCY = LANES + DOT_W + 1;  // Accepting edge to corr_valid
    localparam int TIMEOUT = 400;

    logic                    clk;
    logic                    rst;
    logic                    frame_valid;
    logic                    frame_ready;
    logic [LANES*DOT_W-1:0]  dot_product;
    logic [LANES*NORM_W-1:0] normalizer;
    logic                    corr_valid;
    logic                    corr_ready;
    logic [LANES*CORR_W-1:0] correlation;

    logic [15:0]     lfsr;
    corr_pkg::dot_t  dot_mem  [2][LANES];  // Two frames, so one can wait behind another
    corr_pkg::norm_t norm_mem [2][LANES];

    tb_clock u_clk (
        .clk (clk)
    );

    corr_normalize_top #(
        .LANES (LANES)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .dot_product (dot_product),
        .normalizer  (normalizer),
        .corr_valid  (corr_valid),
        .corr_ready  (corr_ready),
        .correlation (correlation)
    );

    ////////////////////////////////////////////////////
    // Error reporting and reference model
    ////////////////////////////////////////////////////

    function automatic void abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endfunction

    function automatic void report_mismatch(input string name, input logic [63:0] got,
                                            input logic [63:0] want);
        abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want));
    endfunction

    // Saturating floor division where a zero divisor gives 1023
    function automatic corr_pkg::corr_t ref_quot(input corr_pkg::dot_t dot,
                                                 input corr_pkg::norm_t norm);
        corr_pkg::dot_t q;
        if (norm == '0) begin
            return '1;
        end
        q = dot / corr_pkg::dot_t'(norm);
        if (q > corr_pkg::dot_t'(1023)) begin
            return '1;
        end
        return q[CORR_W-1:0];
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        (corr_valid && !corr_ready) |=> (corr_valid && $stable(correlation)))
        else abort_run("corr_valid or correlation changed while corr_ready was low");

    // A held vector blocks new frames
    assert property (@(posedge clk) disable iff (rst)
        corr_valid |-> !frame_ready)
        else abort_run("frame_ready was high while a result vector was held");

    ////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////

    // Ratio spread keeps most quotients under 1024
    task automatic build_random(input int slot);
        int shift;
        for (int i = 0; i < LANES; i++) begin
            shift = int'(rand_bits(3));
            norm_mem[slot][i] = corr_pkg::norm_t'(rand_bits(24)) << shift;
            dot_mem[slot][i]  = corr_pkg::dot_t'(rand_bits(32)) << shift;
        end
    endtask

    task automatic build_edges(input int slot);
        build_random(slot);
        for (int i = 0; i < 6; i++) begin
            norm_mem[slot][i] = '0;
        end
        for (int i = 6; i < 12; i++) begin  // Far above 1023
            dot_mem[slot][i]  = corr_pkg::dot_t'(rand_bits(DOT_W))
                              | (corr_pkg::dot_t'(1) << (DOT_W - 1));
            norm_mem[slot][i] = corr_pkg::norm_t'(rand_bits(8)) + corr_pkg::norm_t'(1);
        end
        dot_mem[slot][12]  = '0;
        norm_mem[slot][12] = corr_pkg::norm_t'(rand_bits(NORM_W)) | corr_pkg::norm_t'(1);
        norm_mem[slot][13] = corr_pkg::norm_t'(rand_bits(NORM_W)) | corr_pkg::norm_t'(1);
        dot_mem[slot][13]  = corr_pkg::dot_t'(norm_mem[slot][13]);
        dot_mem[slot][14]  = '0;
        norm_mem[slot][14] = '0;
        // Around the saturation point
        norm_mem[slot][15] = corr_pkg::norm_t'(7);
        dot_mem[slot][15]  = corr_pkg::dot_t'(7161);
        norm_mem[slot][16] = corr_pkg::norm_t'(7);
        dot_mem[slot][16]  = corr_pkg::dot_t'(7168);
        norm_mem[slot][17] = corr_pkg::norm_t'(7);
        dot_mem[slot][17]  = corr_pkg::dot_t'(7167);
        norm_mem[slot][18] = corr_pkg::norm_t'(7);
        dot_mem[slot][18]  = corr_pkg::dot_t'(7160);
    endtask

    task automatic drive_frame(input int slot);
        for (int i = 0; i < LANES; i++) begin
            dot_product[i*DOT_W +: DOT_W]  = dot_mem[slot][i];
            normalizer[i*NORM_W +: NORM_W] = norm_mem[slot][i];
        end
        frame_valid = 1'b1;
    endtask

    // Returns on the falling edge right after the accepting edge
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        while (!frame_ready) begin
            if (cycles == TIMEOUT) begin
                abort_run("timeout waiting for frame_ready");
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        @(negedge clk);
        frame_valid = 1'b0;
        for (int i = 0; i < LANES; i++) begin  // Upstream moves on at once
            dot_product[i*DOT_W +: DOT_W]  = corr_pkg::dot_t'(rand_bits(DOT_W));
            normalizer[i*NORM_W +: NORM_W] = corr_pkg::norm_t'(rand_bits(NORM_W));
        end
        assert (!frame_ready)
            else report_mismatch("frame_ready", 64'(frame_ready), 64'(0));
    endtask

    task automatic wait_result();
        int edges;
        edges = 0;
        while (!corr_valid) begin
            if (edges == TIMEOUT) begin
                abort_run("timeout waiting for corr_valid");
            end
            @(negedge clk);
            edges++;
        end
        assert (edges == LATENCY)
            else report_mismatch("corr_valid latency", 64'(edges), 64'(LATENCY));
    endtask

    task automatic hold_output(input int cycles);
        repeat (cycles) begin
            assert (corr_valid) else abort_run("corr_valid dropped before the handshake");
            assert (!frame_ready)
                else report_mismatch("frame_ready", 64'(frame_ready), 64'(0));
            @(negedge clk);
        end
    endtask

    task automatic check_vector(input int slot);
        corr_pkg::corr_t got;
        corr_pkg::corr_t want;
        for (int i = 0; i < LANES; i++) begin
            got  = correlation[i*CORR_W +: CORR_W];
            want = ref_quot(dot_mem[slot][i], norm_mem[slot][i]);
            assert (got == want)
                else report_mismatch($sformatf("correlation[%0d]", i), 64'(got), 64'(want));
        end
    endtask

    task automatic check_literal(input int lane, input int value);
        corr_pkg::corr_t got;
        got = correlation[lane*CORR_W +: CORR_W];
        assert (got == corr_pkg::corr_t'(value))
            else report_mismatch($sformatf("correlation[%0d]", lane), 64'(got), 64'(value));
    endtask

    task automatic take_vector();
        corr_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        corr_ready = 1'b0;
        assert (!corr_valid) else abort_run("corr_valid still high after the handshake");
    endtask

    task automatic run_frame(input int slot);
        drive_frame(slot);
        wait_accept();
        wait_result();
        hold_output(int'(rand_bits(2)));
        check_vector(slot);
        take_vector();
    endtask

    ////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////

    initial begin
        int hold;
        rst         = 1'b1;
        frame_valid = 1'b0;
        dot_product = '0;
        normalizer  = '0;
        corr_ready  = 1'b0;
        lfsr        = 16'd65;

        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!corr_valid)
            else report_mismatch("corr_valid", 64'(corr_valid), 64'(0));
        assert (frame_ready)
            else report_mismatch("frame_ready", 64'(frame_ready), 64'(1));

        for (int f = 0; f < 4; f++) begin
            build_random(0);
            run_frame(0);
        end

        build_edges(0);
        drive_frame(0);
        wait_accept();
        wait_result();
        for (int i = 0; i < 12; i++) begin
            check_literal(i, 1023);
        end
        check_literal(12, 0);
        check_literal(13, 1);
        check_literal(14, 1023);
        check_literal(15, 1023);
        check_literal(16, 1023);
        check_literal(17, 1023);
        check_literal(18, 1022);
        check_vector(0);
        take_vector();

        // Second frame waits behind an unread vector
        build_random(0);
        drive_frame(0);
        wait_accept();
        wait_result();
        build_random(1);
        drive_frame(1);
        hold = 4 + int'(rand_bits(4));
        hold_output(hold);
        check_vector(0);
        take_vector();
        wait_accept();
        wait_result();
        check_vector(1);
        take_vector();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

// Free running clock for the testbench
module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// File: hw/corr_normalize_top.sv
`timescale 1ns/1ps

// Division stage of the correlation engine
module corr_normalize_top #(
    parameter int LANES = 48
) (
    input  logic                              clk,
    input  logic                              rst,

    // Frame input
    input  logic                              frame_valid,
    output logic                              frame_ready,
    input  logic [LANES*corr_pkg::DOT_W-1:0]  dot_product,
    input  logic [LANES*corr_pkg::NORM_W-1:0] normalizer,

    // Result output
    output logic                              corr_valid,
    input  logic                              corr_ready,
    output logic [LANES*corr_pkg::CORR_W-1:0] correlation
);

    localparam int TAG_W = $clog2(LANES);

    logic             collector_idle;
    logic             res_valid;
    logic [TAG_W-1:0] res_tag;
    corr_pkg::corr_t  res_quot;

    div_req_if #(.TAG_W(TAG_W)) req_bus ();

    ////////////////////////////////////////////////////
    // Scheduler, divider, collector
    ////////////////////////////////////////////////////

    lane_scheduler #(
        .LANES (LANES),
        .TAG_W (TAG_W)
    ) u_sched (
        .clk            (clk),
        .rst            (rst),
        .frame_valid    (frame_valid),
        .frame_ready    (frame_ready),
        .dot_product    (dot_product),
        .normalizer     (normalizer),
        .collector_idle (collector_idle),
        .req            (req_bus.source)
    );

    norm_divider #(
        .TAG_W (TAG_W)
    ) u_div (
        .clk       (clk),
        .rst       (rst),
        .req       (req_bus.sink),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_quot  (res_quot)
    );

    corr_collector #(
        .LANES (LANES),
        .TAG_W (TAG_W)
    ) u_coll (
        .clk            (clk),
        .rst            (rst),
        .res_valid      (res_valid),
        .res_tag        (res_tag),
        .res_quot       (res_quot),
        .collector_idle (collector_idle),
        .corr_valid     (corr_valid),
        .corr_ready     (corr_ready),
        .correlation    (correlation)
    );

endmodule

// File: hw/corr_collector.sv
`timescale 1ns/1ps

// Rebuilds the correlation vector from tagged quotients
module corr_collector #(
    parameter int LANES = 48,
    parameter int TAG_W = 6
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              res_valid,
    input  logic [TAG_W-1:0]                  res_tag,
    input  corr_pkg::corr_t                   res_quot,
    output logic                              collector_idle,
    output logic                              corr_valid,
    input  logic                              corr_ready,
    output logic [LANES*corr_pkg::CORR_W-1:0] correlation
);

    localparam int CNT_W = $clog2(LANES + 1);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(LANES - 1);

    corr_pkg::corr_t  slot [LANES];
    logic [CNT_W-1:0] pend_cnt;     // Lanes received for the current frame
    logic             handshake;

    assign handshake = corr_valid && corr_ready;

    // Busy from the first returning lane until the vector is taken
    assign collector_idle = (pend_cnt == '0) && !res_valid;

    ////////////////////////////////////////////////////
    // Lane count and output valid
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_cnt   <= '0;
            corr_valid <= 1'b0;
        end else if (handshake) begin
            pend_cnt   <= '0;
            corr_valid <= 1'b0;
        end else if (res_valid) begin
            pend_cnt <= pend_cnt + 1'b1;
            if (pend_cnt == LAST_CNT) begin
                corr_valid <= 1'b1;  // Last lane written on this edge
            end
        end
    end

    ////////////////////////////////////////////////////
    // Vector storage
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (res_valid) begin
            slot[res_tag] <= res_quot;
        end
    end

    // Flatten, lane i in slice i
    for (genvar i = 0; i < LANES; i++) begin : g_flat
        assign correlation[i*corr_pkg::CORR_W +: corr_pkg::CORR_W] = slot[i];
    end

endmodule

// File: hw/lane_scheduler.sv
`timescale 1ns/1ps

// Latches a frame and feeds its lanes to the divider, one per cycle
module lane_scheduler #(
    parameter int LANES = 48,
    parameter int TAG_W = 6
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              frame_valid,
    output logic                              frame_ready,
    input  logic [LANES*corr_pkg::DOT_W-1:0]  dot_product,
    input  logic [LANES*corr_pkg::NORM_W-1:0] normalizer,
    input  logic                              collector_idle,
    div_req_if.source                         req
);

    typedef enum logic {
        IDLE,
        ISSUE
    } sched_state_t;

    localparam logic [TAG_W-1:0] LAST_LANE = TAG_W'(LANES - 1);

    sched_state_t     state;
    logic [TAG_W-1:0] lane_cnt;     // Next lane to issue
    logic             accept;

    // Lane 0 goes out on the accepting edge, so only lanes 1 and up are kept
    corr_pkg::dot_t  lane_dot  [1:LANES-1];
    corr_pkg::norm_t lane_norm [1:LANES-1];

    assign frame_ready = (state == IDLE) && collector_idle;
    assign accept      = frame_valid && frame_ready;

    ////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            lane_cnt  <= '0;
            req.valid <= 1'b0;
        end else begin
            req.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state     <= ISSUE;
                        lane_cnt  <= TAG_W'(1);
                        req.valid <= 1'b1;  // Lane 0
                    end
                end
                ISSUE: begin
                    req.valid <= 1'b1;
                    if (lane_cnt == LAST_LANE) begin
                        state <= IDLE;
                    end else begin
                        lane_cnt <= lane_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////
    // Frame copy and request data
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 1; i < LANES; i++) begin
                lane_dot[i]  <= dot_product[i*corr_pkg::DOT_W +: corr_pkg::DOT_W];
                lane_norm[i] <= normalizer[i*corr_pkg::NORM_W +: corr_pkg::NORM_W];
            end
            req.dividend <= dot_product[0 +: corr_pkg::DOT_W];
            req.divisor  <= normalizer[0 +: corr_pkg::NORM_W];
            req.tag      <= '0;
        end else if (state == ISSUE) begin
            req.dividend <= lane_dot[lane_cnt];
            req.divisor  <= lane_norm[lane_cnt];
            req.tag      <= lane_cnt;
        end
    end

endmodule

// File: hw/norm_divider.sv
`timescale 1ns/1ps

// Restoring divider, one quotient bit per stage, MSB first.
// Result appears DOT_W edges after the request is captured.
module norm_divider #(
    parameter int TAG_W = 6
) (
    input  logic                clk,
    input  logic                rst,
    div_req_if.sink             req,
    output logic                res_valid,
    output logic [TAG_W-1:0]    res_tag,
    output corr_pkg::corr_t     res_quot
);

    localparam int STAGES = corr_pkg::DOT_W;

    // Stage inputs, stage 0 fed straight from the request
    logic            in_valid [STAGES];
    corr_pkg::norm_t in_rem   [STAGES];
    corr_pkg::dot_t  in_dvd   [STAGES];
    corr_pkg::norm_t in_dvs   [STAGES];
    corr_pkg::dot_t  in_quo   [STAGES];
    logic [TAG_W-1:0] in_tag  [STAGES];

    // Stage registers
    logic            s_valid [STAGES];
    corr_pkg::norm_t s_rem   [STAGES];  // Partial remainder
    corr_pkg::dot_t  s_dvd   [STAGES];  // Dividend bits not yet consumed, MSB aligned
    corr_pkg::norm_t s_dvs   [STAGES];
    corr_pkg::dot_t  s_quo   [STAGES];  // Quotient bits so far, LSB newest
    logic [TAG_W-1:0] s_tag  [STAGES];

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        logic [corr_pkg::NORM_W:0] trial;
        logic [corr_pkg::NORM_W:0] diff;
        logic                      fits;

        if (k == 0) begin : g_head
            assign in_valid[k] = req.valid;
            assign in_rem[k]   = '0;
            assign in_dvd[k]   = req.dividend;
            assign in_dvs[k]   = req.divisor;
            assign in_quo[k]   = '0;
            assign in_tag[k]   = req.tag;
        end else begin : g_link
            assign in_valid[k] = s_valid[k-1];
            assign in_rem[k]   = s_rem[k-1];
            assign in_dvd[k]   = s_dvd[k-1];
            assign in_dvs[k]   = s_dvs[k-1];
            assign in_quo[k]   = s_quo[k-1];
            assign in_tag[k]   = s_tag[k-1];
        end

        // Shift in next dividend bit, try to subtract
        assign trial = {in_rem[k], in_dvd[k][corr_pkg::DOT_W-1]};
        assign diff  = trial - {1'b0, in_dvs[k]};
        assign fits  = trial >= {1'b0, in_dvs[k]};  // Always true for a zero divisor

        always_ff @(posedge clk) begin
            if (rst) begin
                s_valid[k] <= 1'b0;
            end else begin
                s_valid[k] <= in_valid[k];
            end
        end

        always_ff @(posedge clk) begin
            s_rem[k] <= fits ? diff[corr_pkg::NORM_W-1:0] : trial[corr_pkg::NORM_W-1:0];
            s_dvd[k] <= in_dvd[k] << 1;
            s_dvs[k] <= in_dvs[k];
            s_quo[k] <= {in_quo[k][corr_pkg::DOT_W-2:0], fits};
            s_tag[k] <= in_tag[k];
        end
    end

    ////////////////////////////////////////////////////
    // Output stage with saturation
    ////////////////////////////////////////////////////

    logic overflow;

    assign overflow = |s_quo[STAGES-1][corr_pkg::DOT_W-1:corr_pkg::CORR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s_valid[STAGES-1];
        end
    end

    always_ff @(posedge clk) begin
        res_tag  <= s_tag[STAGES-1];
        res_quot <= overflow ? '1 : s_quo[STAGES-1][corr_pkg::CORR_W-1:0];
    end

endmodule

// File: hw/div_req_if.sv
`timescale 1ns/1ps

// One division request per cycle with valid high.
// No ready, since the divider pipeline never stalls.
interface div_req_if #(
    parameter int TAG_W = 6
);

    logic            valid;
    corr_pkg::dot_t  dividend;
    corr_pkg::norm_t divisor;
    logic [TAG_W-1:0] tag;       // Lane index, returned with the quotient

    modport source (
        output valid,
        output dividend,
        output divisor,
        output tag
    );

    modport sink (
        input valid,
        input dividend,
        input divisor,
        input tag
    );

endinterface

// File: hw/corr_pkg.sv
package corr_pkg;

    ////////////////////////////////////////////////////
    // Lane data widths
    ////////////////////////////////////////////////////

    localparam int DOT_W  = 42;  // Dot product, unsigned
    localparam int NORM_W = 32;  // Normalizer, unsigned
    localparam int CORR_W = 10;  // Saturated quotient

    // One lane's dividend
    typedef logic [DOT_W-1:0] dot_t;

    // One lane's divisor
    typedef logic [NORM_W-1:0] norm_t;

    // One lane's correlation, 0 to 1023
    typedef logic [CORR_W-1:0] corr_t;

endpackage
